// ==== common/csrPkg.sv ====
// CSR package for the performance monitor
// address map, privilege modes and the request and response words of the access port
package csrPkg;

  typedef enum logic [1:0] {
    privUser       = 2'd0,
    privSupervisor = 2'd1,
    privMachine    = 2'd3
  } privMode_e;

  // field view of a CSR address, top bits first
  typedef struct packed {
    logic [1:0] rwBits;    // 2'b11 marks a read-only CSR
    logic [1:0] privBits;  // lowest mode allowed in
    logic [2:0] group;
    logic [4:0] index;     // counter number inside a range
  } csrFields_t;

  typedef union packed {
    logic [11:0] raw;
    csrFields_t  fields;
  } csrAddr_u;

  typedef struct packed {
    csrAddr_u    addr;
    logic        write;
    logic [31:0] wdata;
    privMode_e   mode;   // mode of the requesting hart
  } csrReq_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        illegal;
  } csrResp_t;

  //////////////////////////////
  // address map
  //////////////////////////////
  localparam logic [11:0] mcycleBase        = 12'hB00;  // mhpmcounter low halves
  localparam logic [11:0] mcyclehBase       = 12'hB80;  // and high halves
  localparam logic [11:0] userBase          = 12'hC00;  // read-only user aliases
  localparam logic [11:0] userhBase         = 12'hC80;
  localparam logic [11:0] timeAddr          = 12'hC01;
  localparam logic [11:0] timehAddr         = 12'hC81;
  localparam logic [11:0] mtimeHole         = 12'hB01;  // mtime is memory mapped, no CSR here
  localparam logic [11:0] mtimehHole        = 12'hB81;
  localparam logic [11:0] mcounterenAddr    = 12'h306;
  localparam logic [11:0] scounterenAddr    = 12'h106;
  localparam logic [11:0] mcountinhibitAddr = 12'h320;

endpackage

// ==== common/perfEventPkg.sv ====
// performance event package
// pipeline event sources and the counter slot each one feeds
package perfEventPkg;

  typedef struct packed {
    logic instrValid;   // instruction retires this cycle
    logic branch;
    logic jump;
    logic ret;
    logic bpWrong;      // branch predictor missed
    logic loadStallD;   // seen at decode
    logic storeStallD;
    logic dcacheMiss;
    logic icacheMiss;
    logic csrWrite;
    logic exception;
    logic interrupt;
    logic stallE;
    logic stallM;
    logic flushM;
  } pipeEvents_t;

  // counter slots, 1 is the time hole
  localparam int evCycle      = 0;
  localparam int evInstret    = 2;
  localparam int evBranch     = 3;
  localparam int evJump       = 4;
  localparam int evReturn     = 5;
  localparam int evBpWrong    = 6;
  localparam int evLoadStall  = 7;
  localparam int evStoreStall = 8;
  localparam int evDcacheMiss = 9;
  localparam int evIcacheMiss = 10;
  localparam int evCsrWrite   = 11;
  localparam int evException  = 12;
  localparam int evInterrupt  = 13;

endpackage

// ==== counters/counterBank.sv ====
`timescale 1ns/10ps
// counter bank
// 64-bit counters kept as 32-bit halves, with CSR writes and the read mux
module counterBank #(
  parameter int numCounters = 16
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [numCounters-1:0] counterEvents,
  input  logic [31:0]            inhibit,
  input  logic                   access,
  input  logic                   write,
  input  csrPkg::csrAddr_u       addr,
  input  logic [31:0]            wdata,
  input  logic [63:0]            mtime,
  output logic [31:0]            rdata,
  output logic                   hit
);
  import csrPkg::*;

  logic [31:0] lowHalf  [numCounters];
  logic [31:0] highHalf [numCounters];
  logic [31:0] selLow, selHigh;          // halves of the indexed counter
  logic        indexValid;
  logic        isHole;                   // mtime and mtimeh slots
  logic        inLowRange, inHighRange;  // machine or user alias range

  //////////////////////////////
  // counters
  //////////////////////////////
  for (genvar i = 0; i < numCounters; i++) begin : gCounter
    logic [63:0] nextCount;
    logic        writeLow, writeHigh;

    // carry runs from the low half into the high half
    assign nextCount = {highHalf[i], lowHalf[i]} + 64'(counterEvents[i] & ~inhibit[i]);

    assign writeLow  = access & write & (addr.raw == mcycleBase + 12'(i)) &
                       (addr.raw != mtimeHole);
    assign writeHigh = access & write & (addr.raw == mcyclehBase + 12'(i)) &
                       (addr.raw != mtimehHole);

    // a written half takes wdata, the other one keeps the incremented value
    always_ff @(posedge clk) begin
      if (reset) begin
        lowHalf[i]  <= '0;
        highHalf[i] <= '0;
      end else begin
        lowHalf[i]  <= writeLow  ? wdata : nextCount[31:0];
        highHalf[i] <= writeHigh ? wdata : nextCount[63:32];
      end
    end
  end

  //////////////////////////////
  // read side
  //////////////////////////////
  assign indexValid  = int'(addr.fields.index) < numCounters;
  assign isHole      = (addr.raw == mtimeHole) || (addr.raw == mtimehHole);
  assign inLowRange  = (addr.raw[11:5] == mcycleBase[11:5]) ||
                       (addr.raw[11:5] == userBase[11:5]);
  assign inHighRange = (addr.raw[11:5] == mcyclehBase[11:5]) ||
                       (addr.raw[11:5] == userhBase[11:5]);

  always_comb begin
    selLow  = '0;
    selHigh = '0;
    for (int i = 0; i < numCounters; i++) begin
      if (addr.fields.index == 5'(i)) begin
        selLow  = lowHalf[i];
        selHigh = highHalf[i];
      end
    end
  end

  always_comb begin
    rdata = '0;
    hit   = 1'b0;
    if (addr.raw == timeAddr) begin          // shadow of the machine timer
      rdata = mtime[31:0];
      hit   = 1'b1;
    end else if (addr.raw == timehAddr) begin
      rdata = mtime[63:32];
      hit   = 1'b1;
    end else if (!isHole && indexValid && inLowRange) begin
      rdata = selLow;
      hit   = 1'b1;
    end else if (!isHole && indexValid && inHighRange) begin
      rdata = selHigh;
      hit   = 1'b1;
    end
  end

  // slot 1 gets no event from the stage and no write through the port
  counterOneFrozen: assert property (@(posedge clk) disable iff (reset)
    $stable({highHalf[1], lowHalf[1]}));

endmodule

// ==== counters/counterConfig.sv ====
`timescale 1ns/10ps
// counter configuration registers
// inhibit, machine enable and supervisor enable masks with write and readback
module counterConfig #(
  parameter int numCounters = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             access,
  input  logic             write,
  input  csrPkg::csrAddr_u addr,
  input  logic [31:0]      wdata,
  output logic [31:0]      rdata,
  output logic             hit,
  output logic [31:0]      inhibit,
  output logic [31:0]      mEnable,
  output logic [31:0]      sEnable
);
  import csrPkg::*;

  // one bit per counter that exists
  localparam logic [31:0] existMask =
    (numCounters >= 32) ? 32'hFFFF_FFFF : (32'd1 << numCounters) - 32'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      inhibit <= '0;   // everything counts
      mEnable <= '0;   // lower modes locked out
      sEnable <= '0;
    end else if (access && write) begin
      case (addr.raw)
        mcountinhibitAddr: inhibit <= wdata & existMask;
        mcounterenAddr:    mEnable <= wdata;
        scounterenAddr:    sEnable <= wdata;
        default: ;         // not one of ours
      endcase
    end
  end

  //////////////////////////////
  // readback
  //////////////////////////////
  always_comb begin
    rdata = '0;
    hit   = 1'b1;
    case (addr.raw)
      mcountinhibitAddr: rdata = inhibit;
      mcounterenAddr:    rdata = mEnable;
      scounterenAddr:    rdata = sEnable;
      default:           hit   = 1'b0;
    endcase
  end

endmodule

// ==== perfCounter.f ====
common/csrPkg.sv
common/perfEventPkg.sv
src/eventStage.sv
counters/counterBank.sv
counters/counterConfig.sv
src/csrAccessPort.sv
src/perfCounterTop.sv
verif/perfCounterTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# builds the performance monitor testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module perfCounterTb \
  --Mdir obj_dir \
  -f perfCounter.f

# a failing check ends in $fatal, which gives a nonzero exit status
./obj_dir/VperfCounterTb

// ==== src/csrAccessPort.sv ====
`timescale 1ns/10ps
// CSR access port
// four-phase req/ack front end that checks access rules and strobes bank and config
module csrAccessPort (
  input  logic             clk,
  input  logic             reset,
  input  logic             req,
  output logic             ack,
  input  csrPkg::csrReq_t  request,
  output csrPkg::csrResp_t response,
  output logic             access,
  output logic             write,
  output csrPkg::csrAddr_u addr,
  output logic [31:0]      wdata,
  input  logic [31:0]      bankRdata,
  input  logic             bankHit,
  input  logic [31:0]      cfgRdata,
  input  logic             cfgHit,
  input  logic [31:0]      mEnable,
  input  logic [31:0]      sEnable
);
  import csrPkg::*;

  typedef enum logic [1:0] {stIdle, stAccess, stAck, stRelease} portState_e;

  portState_e state;
  csrReq_t    held;           // request taken at the first edge
  logic       userAlias;      // 0xC00 or 0xC80 range
  logic       enableBlocked;
  logic       illegal;

  //////////////////////////////
  // handshake FSM
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle:    if (req) state <= stAccess;
        stAccess:  state <= stAck;            // access performed here and ack rises
        stAck:     if (!req) state <= stRelease;
        stRelease: state <= stIdle;           // ack already low
        default:   state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == stIdle && req) held <= request;
    if (state == stAccess) begin
      response.rdata   <= illegal ? 32'd0 : (bankHit ? bankRdata : cfgRdata);
      response.illegal <= illegal;
    end
  end

  //////////////////////////////
  // access rules
  //////////////////////////////
  assign userAlias = (held.addr.raw[11:5] == userBase[11:5]) ||
                     (held.addr.raw[11:5] == userhBase[11:5]);

  always_comb begin
    enableBlocked = 1'b0;
    if (userAlias && held.mode != privMachine) begin
      enableBlocked = !mEnable[held.addr.fields.index] ||
                      (held.mode == privUser && !sEnable[held.addr.fields.index]);
    end
  end

  assign illegal = (held.addr.fields.privBits > 2'(held.mode)) ||
                   (held.write && held.addr.fields.rwBits == 2'b11) ||  // read-only
                   enableBlocked || !(bankHit || cfgHit);

  assign access = (state == stAccess);
  assign write  = access & held.write & ~illegal;
  assign addr   = held.addr;
  assign wdata  = held.wdata;
  assign ack    = (state == stAck);

  ackNeedsReq: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req));

endmodule

// ==== src/eventStage.sv ====
`timescale 1ns/10ps
// pipeline event stage
// carries decode stalls to memory stage and maps every source onto its counter slot
module eventStage #(
  parameter int numCounters = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  perfEventPkg::pipeEvents_t events,
  output logic [numCounters-1:0]    counterEvents
);
  import perfEventPkg::*;

  typedef struct packed {
    logic load;
    logic store;
  } memStall_t;

  memStall_t   stallsE;     // decode stalls now in execute
  memStall_t   stallsM;     // and in memory, where they count
  logic [31:0] allEvents;   // full 32 slots, trimmed to the bank size below

  //////////////////////////////
  // stall pipeline
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      stallsE <= '0;
    end else if (!events.stallE) begin  // hold while execute stalls
      stallsE <= {events.loadStallD, events.storeStallD};
    end
  end

  // a flush wipes the memory stage whatever its stall
  always_ff @(posedge clk) begin
    if (reset || events.flushM) begin
      stallsM <= '0;
    end else if (!events.stallM) begin
      stallsM <= stallsE;
    end
  end

  //////////////////////////////
  // slot mapping
  //////////////////////////////
  always_comb begin
    allEvents                = '0;  // slot 1 and slots above 13 never count
    allEvents[evCycle]       = 1'b1;
    allEvents[evInstret]     = events.instrValid;
    allEvents[evBranch]      = events.branch & events.instrValid;   // retire qualified
    allEvents[evJump]        = events.jump & events.instrValid;
    allEvents[evReturn]      = events.ret & events.instrValid;
    allEvents[evBpWrong]     = events.bpWrong & events.instrValid;
    allEvents[evLoadStall]   = stallsM.load;
    allEvents[evStoreStall]  = stallsM.store;
    allEvents[evDcacheMiss]  = events.dcacheMiss;
    allEvents[evIcacheMiss]  = events.icacheMiss;
    allEvents[evCsrWrite]    = events.csrWrite & events.instrValid;
    allEvents[evException]   = events.exception;  // no retire on a trap
    allEvents[evInterrupt]   = events.interrupt;
  end

  assign counterEvents = allEvents[numCounters-1:0];

endmodule

// ==== src/perfCounterTop.sv ====
`timescale 1ns/10ps
// performance monitor top level
module perfCounterTop #(
  parameter int numCounters = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req,
  output logic                      ack,
  input  csrPkg::csrReq_t           request,
  output csrPkg::csrResp_t          response,
  input  perfEventPkg::pipeEvents_t events,
  input  logic [63:0]               mtime
);
  import csrPkg::*;

  logic [numCounters-1:0] counterEvents;
  logic                   access, write;
  csrAddr_u               accessAddr;
  logic [31:0]            accessWdata;
  logic [31:0]            bankRdata, cfgRdata;
  logic                   bankHit, cfgHit;
  logic [31:0]            inhibit, mEnable, sEnable;

  eventStage #(.numCounters(numCounters)) uEventStage (
    .clk, .reset, .events, .counterEvents
  );

  counterBank #(.numCounters(numCounters)) uCounterBank (
    .clk, .reset, .counterEvents, .inhibit, .access, .write,
    .addr(accessAddr), .wdata(accessWdata), .mtime,
    .rdata(bankRdata), .hit(bankHit)
  );

  counterConfig #(.numCounters(numCounters)) uCounterConfig (
    .clk, .reset, .access, .write, .addr(accessAddr), .wdata(accessWdata),
    .rdata(cfgRdata), .hit(cfgHit), .inhibit, .mEnable, .sEnable
  );

  csrAccessPort uCsrAccessPort (
    .clk, .reset, .req, .ack, .request, .response,
    .access, .write, .addr(accessAddr), .wdata(accessWdata),
    .bankRdata, .bankHit, .cfgRdata, .cfgHit, .mEnable, .sEnable
  );

endmodule

// ==== verif/perfCounterTb.sv ====
`timescale 1ns/10ps
// testbench for the performance monitor
// CSR handshakes and event bursts checked against a reference model of counters and masks
module perfCounterTb;
  import csrPkg::*;
  import perfEventPkg::*;

  localparam int numCounters = 16;
  localparam int slotBits    = $clog2(numCounters);
  localparam int retireCount = 20;
  localparam int randomBurst = 200;
  localparam int stallBurst  = 200;
  localparam int numAccesses = 80;                                  // bound on handshakes
  localparam int eventCycles = retireCount + randomBurst + stallBurst + 6;  // two drain per run
  localparam logic [31:0] allOnes = 32'hFFFF_FFFF;

  logic        clk;
  logic        reset;
  logic        req;
  logic        ack;
  csrReq_t     request;
  csrResp_t    response;
  pipeEvents_t events;
  logic [63:0] mtime;

  integer      seed;
  int          accessCount;
  int          checkCount;
  csrResp_t    expResp;                  // expected answer of the access in flight
  logic [31:0] lowModel  [numCounters];
  logic [31:0] highModel [numCounters];
  logic [31:0] inhibitModel, mEnModel, sEnModel;
  logic [1:0]  pipeE, pipeM;             // {load, store} stalls in execute and memory

  perfCounterTop #(.numCounters(numCounters)) DUT (
    .clk, .reset, .req, .ack, .request, .response, .events, .mtime
  );

  always #50 clk = ~clk;

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic csrResp_t expectedResp(input csrReq_t r);
    logic [11:0]         a;
    logic [4:0]          idx;
    logic [slotBits-1:0] slot;
    logic                known;
    logic                blocked;
    logic [31:0]         value;
    csrResp_t            resp;
    a       = r.addr.raw;
    idx     = a[4:0];
    slot    = a[slotBits-1:0];
    known   = 1'b1;
    blocked = 1'b0;
    value   = '0;
    if (a == timeAddr) value = mtime[31:0];
    else if (a == timehAddr) value = mtime[63:32];
    else if (a == mcountinhibitAddr) value = inhibitModel;
    else if (a == mcounterenAddr) value = mEnModel;
    else if (a == scounterenAddr) value = sEnModel;
    else if (a == mtimeHole || a == mtimehHole || int'(idx) >= numCounters) known = 1'b0;
    else if (a[11:5] == mcycleBase[11:5] || a[11:5] == userBase[11:5]) value = lowModel[slot];
    else if (a[11:5] == mcyclehBase[11:5] || a[11:5] == userhBase[11:5]) value = highModel[slot];
    else known = 1'b0;
    // user aliases need the machine enable, and the supervisor one too from user mode
    if ((a[11:5] == userBase[11:5] || a[11:5] == userhBase[11:5]) && r.mode != privMachine)
      blocked = !mEnModel[idx] || (r.mode == privUser && !sEnModel[idx]);
    resp.illegal = (a[9:8] > r.mode) || (r.write && a[11:10] == 2'b11) || blocked || !known;
    resp.rdata   = resp.illegal ? 32'd0 : value;
    return resp;
  endfunction

  task automatic commitWrite(input csrReq_t r);
    logic [11:0]         a;
    logic [slotBits-1:0] slot;
    csrResp_t            resp;
    a    = r.addr.raw;
    slot = a[slotBits-1:0];
    resp = expectedResp(r);
    if (!r.write || resp.illegal) return;  // suppressed write
    if (a == mcountinhibitAddr) inhibitModel = r.wdata & ((32'd1 << numCounters) - 32'd1);
    else if (a == mcounterenAddr) mEnModel = r.wdata;
    else if (a == scounterenAddr) sEnModel = r.wdata;
    else if (a[11:5] == mcycleBase[11:5]) lowModel[slot] = r.wdata;
    else if (a[11:5] == mcyclehBase[11:5]) highModel[slot] = r.wdata;
  endtask

  // one clock edge of event counting
  task automatic stepModel(input pipeEvents_t ev);
    logic [31:0] evVec;
    logic [63:0] count;
    int          i;
    evVec               = '0;
    evVec[evCycle]      = 1'b1;
    evVec[evInstret]    = ev.instrValid;
    evVec[evBranch]     = ev.branch & ev.instrValid;
    evVec[evJump]       = ev.jump & ev.instrValid;
    evVec[evReturn]     = ev.ret & ev.instrValid;
    evVec[evBpWrong]    = ev.bpWrong & ev.instrValid;
    evVec[evLoadStall]  = pipeM[1];   // counted at memory stage
    evVec[evStoreStall] = pipeM[0];
    evVec[evDcacheMiss] = ev.dcacheMiss;
    evVec[evIcacheMiss] = ev.icacheMiss;
    evVec[evCsrWrite]   = ev.csrWrite & ev.instrValid;
    evVec[evException]  = ev.exception;
    evVec[evInterrupt]  = ev.interrupt;
    for (i = 0; i < numCounters; i++) begin
      if (evVec[i] && !inhibitModel[i]) begin
        count = {highModel[i], lowModel[i]} + 64'd1;   // carry into the high half
        {highModel[i], lowModel[i]} = count;
      end
    end
    if (ev.flushM) pipeM = 2'b00;           // flush drops whatever sits in memory
    else if (!ev.stallM) pipeM = pipeE;
    if (!ev.stallE) pipeE = {ev.loadStallD, ev.storeStallD};
  endtask

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////
  task automatic driveCycle(input pipeEvents_t ev);
    @(posedge clk);
    #1;
    events = ev;
    stepModel(ev);
  endtask

  task automatic runBurst(input int cycles, input logic stallOnly);
    logic [31:0] rnd;
    pipeEvents_t ev;
    int          n;
    for (n = 0; n < cycles; n++) begin
      rnd = $random(seed);
      if (stallOnly) begin
        ev             = '0;
        ev.loadStallD  = rnd[0];
        ev.storeStallD = rnd[1];
        ev.stallE      = rnd[2] & rnd[3];    // about a quarter of the cycles
        ev.stallM      = rnd[4] & rnd[5];
        ev.flushM      = rnd[8:6] == 3'd0;
      end else begin
        ev = rnd[14:0];
      end
      driveCycle(ev);
    end
    driveCycle('0);   // empty both stall stages
    driveCycle('0);
  endtask

  task automatic csrTask(input logic [11:0] addr, input logic wr, input logic [31:0] data,
                         input privMode_e mode);
    csrReq_t r;
    r.addr.raw = addr;
    r.write    = wr;
    r.wdata    = data;
    r.mode     = mode;
    @(posedge clk);
    #1;
    expResp = expectedResp(r);
    request = r;
    req     = 1'b1;
    accessCount++;
    @(posedge clk);
    #1;
    while (!ack) begin
      @(posedge clk);
      #1;
    end
    commitWrite(r);
    req = 1'b0;       // released as soon as ack is seen
    while (ack) begin
      @(posedge clk);
      #1;
    end
  endtask

  // compares each response while ack is high
  always @(posedge ack) begin
    #1;
    checkCount++;
    assert (response == expResp) else begin
      $display("Mismatch response at %h: rdata %h expected %h, illegal %h expected %h",
               request.addr.raw, response.rdata, expResp.rdata,
               response.illegal, expResp.illegal);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  initial begin
    #((numAccesses * 20 + eventCycles + 100) * 100);
    $display("Watchdog timeout, the run did not complete in time");
    $display("Testbench failed");
    $fatal(1);
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin : mainSeq
    pipeEvents_t ev;
    int          k;
    clk          = 1'b0;
    reset        = 1'b1;
    req          = 1'b0;
    request      = '0;
    events       = '0;
    seed         = 30;
    accessCount  = 0;
    checkCount   = 0;
    expResp      = '0;
    inhibitModel = '0;
    mEnModel     = '0;
    sEnModel     = '0;
    pipeE        = '0;
    pipeM        = '0;
    mtime[63:32] = $random(seed);
    mtime[31:0]  = $random(seed);
    for (k = 0; k < numCounters; k++) begin
      lowModel[k]  = '0;
      highModel[k] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // frozen counters take and return written halves
    csrTask(mcountinhibitAddr, 1'b1, allOnes, privMachine);
    csrTask(mcountinhibitAddr, 1'b0, 32'd0, privMachine);
    csrTask(mcycleBase + 12'd4, 1'b1, 32'hDEAD_BEEF, privMachine);
    csrTask(mcyclehBase + 12'd4, 1'b1, 32'h0123_4567, privMachine);
    csrTask(mcycleBase + 12'd9, 1'b1, $random(seed), privMachine);
    csrTask(mcyclehBase + 12'd9, 1'b1, $random(seed), privMachine);
    csrTask(mcycleBase + 12'd4, 1'b0, 32'd0, privMachine);
    csrTask(mcyclehBase + 12'd4, 1'b0, 32'd0, privMachine);
    csrTask(userBase + 12'd9, 1'b0, 32'd0, privMachine);
    csrTask(userhBase + 12'd9, 1'b0, 32'd0, privMachine);
    csrTask(userBase, 1'b1, 32'h5555_AAAA, privMachine);     // read-only alias
    csrTask(userBase + 12'd4, 1'b1, 32'h5555_AAAA, privMachine);
    csrTask(mcycleBase + 12'd4, 1'b0, 32'd0, privMachine);

    // instret alone wraps its low half into the high half
    csrTask(mcycleBase + 12'd2, 1'b1, allOnes, privMachine);
    csrTask(mcyclehBase + 12'd2, 1'b1, 32'h0000_0041, privMachine);
    csrTask(mcountinhibitAddr, 1'b1, ~(32'd1 << evInstret), privMachine);
    ev            = '0;
    ev.instrValid = 1'b1;
    repeat (retireCount) driveCycle(ev);
    driveCycle('0);
    driveCycle('0);
    csrTask(mcountinhibitAddr, 1'b1, allOnes, privMachine);
    csrTask(mcycleBase + 12'd2, 1'b0, 32'd0, privMachine);
    csrTask(mcyclehBase + 12'd2, 1'b0, 32'd0, privMachine);

    // random events with every slot but the cycle counter enabled
    csrTask(mcycleBase + 12'd14, 1'b1, $random(seed), privMachine);
    csrTask(mcycleBase + 12'd15, 1'b1, $random(seed), privMachine);
    csrTask(mcountinhibitAddr, 1'b1, 32'h0000_0001, privMachine);
    runBurst(randomBurst, 1'b0);
    csrTask(mcountinhibitAddr, 1'b1, allOnes, privMachine);
    for (k = 1; k < numCounters; k++) begin
      csrTask(mcycleBase + 12'(k), 1'b0, 32'd0, privMachine);
      csrTask(mcyclehBase + 12'(k), 1'b0, 32'd0, privMachine);
    end

    // load and store stalls through the stage registers
    csrTask(mcountinhibitAddr, 1'b1, ~32'h0000_0180, privMachine);
    runBurst(stallBurst, 1'b1);
    csrTask(mcountinhibitAddr, 1'b1, allOnes, privMachine);
    csrTask(mcycleBase + 12'd7, 1'b0, 32'd0, privMachine);
    csrTask(mcyclehBase + 12'd7, 1'b0, 32'd0, privMachine);
    csrTask(mcycleBase + 12'd8, 1'b0, 32'd0, privMachine);
    csrTask(mcyclehBase + 12'd8, 1'b0, 32'd0, privMachine);

    // privilege and enable masks on the user aliases
    csrTask(userBase + 12'd3, 1'b0, 32'd0, privUser);         // mEnable clear
    csrTask(mcounterenAddr, 1'b1, 32'h0000_0008, privMachine);
    csrTask(userBase + 12'd3, 1'b0, 32'd0, privUser);         // sEnable still clear
    csrTask(scounterenAddr, 1'b1, 32'h0000_0008, privMachine);
    csrTask(userBase + 12'd3, 1'b0, 32'd0, privUser);
    csrTask(userhBase + 12'd3, 1'b0, 32'd0, privUser);
    csrTask(scounterenAddr, 1'b1, 32'd0, privMachine);
    csrTask(userBase + 12'd3, 1'b0, 32'd0, privSupervisor);   // machine enable is enough
    csrTask(scounterenAddr, 1'b0, 32'd0, privSupervisor);
    csrTask(mcounterenAddr, 1'b0, 32'd0, privSupervisor);     // machine-only CSR
    csrTask(mcycleBase + 12'd3, 1'b0, 32'd0, privUser);
    csrTask(mcycleBase + 12'd3, 1'b1, 32'h0000_FFFF, privUser);

    // machine timer shadow and unmapped slots
    csrTask(timeAddr, 1'b0, 32'd0, privMachine);
    csrTask(timehAddr, 1'b0, 32'd0, privMachine);
    csrTask(mtimeHole, 1'b0, 32'd0, privMachine);
    csrTask(userBase + 12'd31, 1'b0, 32'd0, privMachine);

    if (checkCount != accessCount) begin
      $display("Only %0d responses were checked for %0d accesses", checkCount, accessCount);
      $display("Testbench failed");
      $fatal(1);
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule
